/* Bender.yml */
package:
  name: texture_cache

sources:
  - common/texAddrPkg.sv
  - common/texCacheCfgPkg.sv
  - common/cacheReadIf.sv
  - cache/lineStore.sv
  - cache/lineValidBits.sv
  - cache/lookupPort.sv
  - source/textureCache.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/textureCacheTb.sv

/* cache/lineStore.sv */
// tag and word storage with swizzled write port, fill forwarding and two async read ports
`timescale 1ns/10ps
`default_nettype none

module lineStore
	import texAddrPkg::*, texCacheCfgPkg::*;
#(
	parameter int lineIndexBits = defaultLineIndexBits
) (
	input  logic clk,
	input  logic wrValid,
	input  wordAddrT wrAddr,
	input  cacheWordT wrData,
	input  logic trueColor,
	output logic [lineIndexBits-1:0] fillIndex,
	output logic fillStrobe,
	cacheReadIf.store readA,
	cacheReadIf.store readB
);

	localparam int numLines = 1 << lineIndexBits;
	localparam int tagBits = swizzledAddrBits - lineIndexBits;

	typedef logic [lineIndexBits-1:0] lineIndexT;
	typedef logic [tagBits-1:0] tagT;

	// write address after the format swizzle
	wordAddrT wrSwz;
	lineIndexT wrIndex;
	tagT wrTag;

	// storage arrays, one entry per line
	tagT tagMem [numLines];
	cacheWordT wordMem [numLines];

	assign wrSwz = swizzleWordAddr(wrAddr, trueColor);
	assign wrIndex = wrSwz[lineIndexBits-1:0];
	assign wrTag = wrSwz[swizzledAddrBits-1:lineIndexBits];

	// every memory write is snooped so the cache never goes stale
	always_ff @(posedge clk) begin
		if (wrValid) begin
			tagMem[wrIndex] <= wrTag;
			wordMem[wrIndex] <= wrData;
		end
	end

	// the active bit of the written line gets set in the same cycle
	assign fillIndex = wrIndex;
	assign fillStrobe = wrValid;

	// port A read, indexed by its registered lookup address
	assign readA.readTag = tagMem[readA.readIndex];
	assign readA.readWord = wordMem[readA.readIndex];

	// port B read
	assign readB.readTag = tagMem[readB.readIndex];
	assign readB.readWord = wordMem[readB.readIndex];

endmodule

`default_nettype wire

/* cache/lineValidBits.sv */
// per-line active bits with reset, bulk clear, fill set and two read ports
`timescale 1ns/10ps
`default_nettype none

module lineValidBits
	import texCacheCfgPkg::*;
#(
	parameter int lineIndexBits = defaultLineIndexBits
) (
	input  logic clk,
	input  logic rstN,
	input  logic clearCache,
	input  logic [lineIndexBits-1:0] fillIndex,
	input  logic fillStrobe,
	cacheReadIf.valid readA,
	cacheReadIf.valid readB
);

	localparam int numLines = 1 << lineIndexBits;

	typedef logic [numLines-1:0] lineMaskT;

	// one bit per line, set means the stored tag and word are usable
	lineMaskT activeBits;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			activeBits <= '0;
		end else if (clearCache) begin
			// clear takes priority over a fill in the same cycle
			activeBits <= '0;
		end else if (fillStrobe) begin
			activeBits[fillIndex] <= 1'b1;
		end
	end

	// combinational lookups
	// new state is visible right after the edge that changed it
	assign readA.readActive = activeBits[readA.readIndex];
	assign readB.readActive = activeBits[readB.readIndex];

endmodule

`default_nettype wire

/* cache/lookupPort.sv */
// lookup pipeline with address swizzle, tag compare, sticky miss FSM and pixel select
`timescale 1ns/10ps
`default_nettype none

module lookupPort
	import texAddrPkg::*, texCacheCfgPkg::*;
#(
	parameter int lineIndexBits = defaultLineIndexBits
) (
	input  logic clk,
	input  logic rstN,
	input  logic lookValid,
	input  pixelAddrT lookAddr,
	input  logic trueColor,
	output pixelT lookData,
	output logic hit,
	output logic miss,
	cacheReadIf.port rd
);

	localparam int tagBits = swizzledAddrBits - lineIndexBits;

	typedef logic [lineIndexBits-1:0] lineIndexT;
	typedef logic [tagBits-1:0] tagT;

	// sticky miss tracking
	typedef enum logic {
		portIdle,
		portMissPending
	} missStateT;

	// incoming address split and swizzled
	wordAddrT lookWord;
	wordAddrT lookSwz;

	// request stage registers
	lineIndexT reqIndex;
	tagT reqTag;
	pixelSelT reqSel;
	logic reqValid;
	missStateT missState;

	// response stage
	logic tagMatch;
	pixelT [pixelsPerWord-1:0] linePixels;

	assign lookWord = lookAddr[$bits(pixelAddrT)-1:$bits(pixelSelT)];
	assign lookSwz = swizzleWordAddr(lookWord, trueColor);

	// address follows lookAddr every cycle, request or not
	always_ff @(posedge clk) begin
		reqIndex <= lookSwz[lineIndexBits-1:0];
		reqTag <= lookSwz[swizzledAddrBits-1:lineIndexBits];
		reqSel <= lookAddr[$bits(pixelSelT)-1:0];
	end

	// registered address drives the store and active bit reads
	assign rd.readIndex = reqIndex;

	// line hits when it is active and holds the same tag
	assign tagMatch = rd.readActive && (rd.readTag == reqTag);

	// hit only pulses in the response cycle of a request
	assign hit = reqValid && tagMatch;

	// miss pulses on a failed request and then holds while the address still misses
	// a fill of the missing word drops it even without a new request
	assign miss = !tagMatch && (reqValid || (missState == portMissPending));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqValid <= 1'b0;
			missState <= portIdle;
		end else begin
			reqValid <= lookValid;
			// only a hit response leaves the pending state
			case (missState)
				portIdle: begin
					if (miss) begin
						missState <= portMissPending;
					end
				end
				portMissPending: begin
					if (hit) begin
						missState <= portIdle;
					end
				end
				default: begin
					missState <= portIdle;
				end
			endcase
		end
	end

	// pick one of the four texels, pixel 0 in the low bits
	assign linePixels = rd.readWord;
	assign lookData = linePixels[reqSel];

endmodule

`default_nettype wire

/* common/cacheReadIf.sv */
// read-side interface from one lookup port to the line store and the active bits
`timescale 1ns/10ps
`default_nettype none

interface cacheReadIf
	import texAddrPkg::*, texCacheCfgPkg::*;
#(
	parameter int lineIndexBits = defaultLineIndexBits
);

	localparam int tagBits = swizzledAddrBits - lineIndexBits;

	// line selected by the lookup pipeline
	logic [lineIndexBits-1:0] readIndex;
	// stored tag and word of that line
	logic [tagBits-1:0] readTag;
	cacheWordT readWord;
	// line holds valid data
	logic readActive;

	// lookup side drives the index and gets everything back combinationally
	modport port (output readIndex, input readTag, input readWord, input readActive);

	// tag and data storage
	modport store (input readIndex, output readTag, output readWord);

	// active bit register block
	modport valid (input readIndex, output readActive);

endinterface

`default_nettype wire

/* common/texAddrPkg.sv */
// video memory address, pixel and cache word types, texture format swizzle function
`default_nettype none

package texAddrPkg;

	// 64-bit word address inside the 1 MB video memory
	typedef logic [16:0] wordAddrT;

	// 16-bit pixel address
	// upper 17 bits select the word, low 2 bits the pixel inside it
	typedef logic [18:0] pixelAddrT;

	// one texel
	typedef logic [15:0] pixelT;

	// four texels, pixel 0 in the lowest 16 bits
	typedef logic [63:0] cacheWordT;

	// pixel position inside a cache word
	typedef logic [1:0] pixelSelT;

	// remap a word address so neighbouring texture rows spread over the lines
	// low bits of the result form the line index, the rest is the tag
	function automatic wordAddrT swizzleWordAddr(input wordAddrT addr, input logic trueColor);
		wordAddrT swz;
		if (trueColor) begin
			// 16 bpp block layout, 4/5/5/3 split
			swz = {addr[16:13], addr[7:3], addr[12:8], addr[2:0]};
		end else begin
			// 8/4 bpp block layout, 3/6/6/2 split
			swz = {addr[16:14], addr[7:2], addr[13:8], addr[1:0]};
		end
		return swz;
	endfunction

endpackage

`default_nettype wire

/* common/texCacheCfgPkg.sv */
// texture cache geometry defaults and address split constants
`default_nettype none

package texCacheCfgPkg;

	// index bits of the direct-mapped store
	// 8 gives 256 lines (2 KB), 9 gives 512 lines (4 KB)
	localparam int defaultLineIndexBits = 8;

	// width of the swizzled word address, index plus tag
	localparam int swizzledAddrBits = 17;

	// texels packed into one 64-bit cache word
	localparam int pixelsPerWord = 4;

	// tag width follows as swizzledAddrBits - lineIndexBits
	// each module derives it from its own parameter

endpackage

`default_nettype wire

/* compile.f */
+incdir+dv
common/texAddrPkg.sv
common/texCacheCfgPkg.sv
common/cacheReadIf.sv
cache/lineStore.sv
cache/lineValidBits.sv
cache/lookupPort.sv
source/textureCache.sv
dv/textureCacheTb.sv

/* dv/cacheTests.svh */
// directed tests: empty cache, fill and read, dual ports, format conflict, sticky miss, clear

	task automatic testEmptyAfterReset();
		lookupPair("emptyAfterReset", pixelAddrT'(randBits(19)), pixelAddrT'(randBits(19)));
		checkValue("emptyAfterReset", "missA", 1, missA);
		checkValue("emptyAfterReset", "missB", 1, missB);
	endtask

	task automatic testFillThenRead();
		fillRandom(8);
		// every pixel of every word
		foreach (filledWords[i]) begin
			for (int s = 0; s < pixelsPerWord; s++) begin
				lookupOne("fillThenRead", 1'b0, {filledWords[i], 2'(s)});
				checkValue("fillThenRead", "hitA", 1, hitA);
			end
		end
	endtask

	task automatic testDualPorts();
		wordAddrT absent;
		for (int i = 0; i + 1 < filledWords.size(); i++) begin
			lookupPair("dualPorts", {filledWords[i], 2'(randBits(2))},
				{filledWords[i+1], 2'(randBits(2))});
			checkValue("dualPorts", "hitA", 1, hitA);
			checkValue("dualPorts", "hitB", 1, hitB);
		end
		// A on an empty line while B hits
		do begin
			absent = wordAddrT'(randBits(17));
		end while (modelActive[modelIndex(absent)]);
		lookupPair("dualPorts", {absent, 2'b01}, {filledWords[0], 2'b10});
		checkValue("dualPorts", "missA", 1, missA);
		checkValue("dualPorts", "hitB", 1, hitB);
	endtask

	task automatic testFormatConflict();
		wordAddrT first;
		wordAddrT second;
		clearCacheNow();
		for (int m = 1; m >= 0; m--) begin
			trueColor = m[0];
			// bit 13 lands in the tag for true color but in the index for paletted
			// bit 2 is the other way round
			first = wordAddrT'(randBits(17));
			second = first ^ (m[0] ? 17'h02000 : 17'h00004);
			writeWord(first, randBits(64));
			writeWord(second, randBits(64));
			lookupOne("formatConflict", 1'b0, {first, 2'(randBits(2))});
			checkValue("formatConflict", "missA", 1, missA);
			lookupOne("formatConflict", 1'b0, {second, 2'(randBits(2))});
			checkValue("formatConflict", "hitA", 1, hitA);
			clearCacheNow();
		end
		trueColor = 1'b1;
	endtask

	task automatic testStickyMiss();
		wordAddrT addr;
		pixelAddrT pa;
		addr = wordAddrT'(randBits(17));
		pa = {addr, 2'(randBits(2))};
		lookupOne("stickyMiss", 1'b0, pa);
		checkValue("stickyMiss", "missA", 1, missA);
		// request dropped, address held
		for (int i = 0; i < 3; i++) begin
			nextCycle();
			checkValue("stickyMiss", "missA", 1, missA);
			checkValue("stickyMiss", "hitA", 0, hitA);
		end
		writeWord(addr, randBits(64));
		checkValue("stickyMiss", "missA", 0, missA);
		checkValue("stickyMiss", "hitA", 0, hitA);
		lookupOne("stickyMiss", 1'b0, pa);
		checkValue("stickyMiss", "hitA", 1, hitA);
	endtask

	task automatic testClearAndWrite();
		pixelAddrT pa;
		fillRandom(4);
		foreach (filledWords[i]) begin
			lookupOne("clearAndWrite", 1'b0, {filledWords[i], 2'(i)});
			checkValue("clearAndWrite", "hitA", 1, hitA);
		end
		clearCacheNow();
		foreach (filledWords[i]) begin
			lookupOne("clearAndWrite", 1'b0, {filledWords[i], 2'(i)});
			checkValue("clearAndWrite", "missA", 1, missA);
		end
		// lookup on the same edge as the write to its word
		pa = {filledWords[0], 2'b11};
		driveWrite(filledWords[0], randBits(64));
		requestLookup(1'b0, pa);
		awaitResponse("clearAndWrite", 1'b1, 1'b0);
		checkPort("clearAndWrite", 1'b0, pa);
		checkValue("clearAndWrite", "hitA", 1, hitA);
	endtask

/* dv/textureCacheTb.sv */
// texture cache testbench top with clock, reset, DUT, LFSR, reference model, drivers and checks
`timescale 1ns/10ps
`default_nettype none

module textureCacheTb
	import texAddrPkg::*, texCacheCfgPkg::*;
();

	localparam int indexBits = defaultLineIndexBits;
	localparam int numLines = 1 << indexBits;
	localparam int resetCycles = 5;
	localparam int responseTimeout = 8;
	localparam logic [31:0] lfsrSeed = 32'h2dae56de;
	// x^32 + x^22 + x^2 + x + 1, right shifting form
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	logic clk;
	logic rstN;
	logic clearCache;
	logic trueColor;
	logic wrValid;
	wordAddrT wrAddr;
	cacheWordT wrData;
	logic lookValidA;
	pixelAddrT lookAddrA;
	pixelT lookDataA;
	logic hitA;
	logic missA;
	logic lookValidB;
	pixelAddrT lookAddrB;
	pixelT lookDataB;
	logic hitB;
	logic missB;

	logic [31:0] lfsrState;

	// reference model of the cache contents
	logic modelActive [numLines];
	wordAddrT modelTag [numLines];
	cacheWordT modelWord [numLines];
	// words written by the last random fill
	wordAddrT filledWords [$];

	textureCache textureCache_i (.*);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one output bit per LFSR step
	function automatic logic [63:0] randBits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value[i] = lfsrState[0];
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
		end
		return value;
	endfunction

	// word address remap, written out field by field
	function automatic wordAddrT modelSwizzle(input wordAddrT addr, input logic fmt);
		logic [31:0] a;
		logic [31:0] r;
		a = 32'(addr);
		if (fmt) begin
			// 16..13 | 7..3 | 12..8 | 2..0
			r = (((a >> 13) & 32'hf) << 13) | (((a >> 3) & 32'h1f) << 8)
				| (((a >> 8) & 32'h1f) << 3) | (a & 32'h7);
		end else begin
			// 16..14 | 7..2 | 13..8 | 1..0
			r = (((a >> 14) & 32'h7) << 14) | (((a >> 2) & 32'h3f) << 8)
				| (((a >> 8) & 32'h3f) << 2) | (a & 32'h3);
		end
		return wordAddrT'(r);
	endfunction

	// low bits of the swizzled address pick the line
	function automatic int modelIndex(input wordAddrT addr);
		return int'(modelSwizzle(addr, trueColor)) % numLines;
	endfunction

	function automatic wordAddrT modelTagOf(input wordAddrT addr);
		return modelSwizzle(addr, trueColor) >> indexBits;
	endfunction

	function automatic logic modelHit(input pixelAddrT pa);
		int idx;
		idx = modelIndex(pa[18:2]);
		return modelActive[idx] && (modelTag[idx] == modelTagOf(pa[18:2]));
	endfunction

	function automatic pixelT modelPixel(input pixelAddrT pa);
		cacheWordT word;
		word = modelWord[modelIndex(pa[18:2])];
		return word[pa[1:0]*16 +: 16];
	endfunction

	task automatic checkValue(input string testName, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s in %s", what, testName);
		end
	endtask

	// advance to just after the next edge, strobes drop back to idle
	task automatic nextCycle();
		@(posedge clk);
		#1;
		wrValid = 1'b0;
		clearCache = 1'b0;
		lookValidA = 1'b0;
		lookValidB = 1'b0;
	endtask

	task automatic driveWrite(input wordAddrT addr, input cacheWordT data);
		int idx;
		idx = modelIndex(addr);
		wrValid = 1'b1;
		wrAddr = addr;
		wrData = data;
		modelActive[idx] = 1'b1;
		modelTag[idx] = modelTagOf(addr);
		modelWord[idx] = data;
	endtask

	task automatic writeWord(input wordAddrT addr, input cacheWordT data);
		driveWrite(addr, data);
		nextCycle();
	endtask

	task automatic clearCacheNow();
		clearCache = 1'b1;
		foreach (modelActive[i]) modelActive[i] = 1'b0;
		nextCycle();
	endtask

	task automatic requestLookup(input logic portB, input pixelAddrT pa);
		if (portB) begin
			lookValidB = 1'b1;
			lookAddrB = pa;
		end else begin
			lookValidA = 1'b1;
			lookAddrA = pa;
		end
	endtask

	// wait for hit or miss on the selected ports, exactly one cycle is expected
	task automatic awaitResponse(input string testName, input logic useA, input logic useB);
		int cycles;
		logic done;
		cycles = 0;
		do begin
			nextCycle();
			cycles++;
			done = (!useA || hitA || missA) && (!useB || hitB || missB);
		end while (!done && cycles < responseTimeout);
		if (!done) begin
			$display("no lookup response within %0d cycles in %s", responseTimeout, testName);
			$display("Result: FAILED");
			$fatal(1, "lookup response timeout");
		end else begin
			checkValue(testName, "latency", 1, cycles);
		end
	endtask

	// compare one port with the model
	task automatic checkPort(input string testName, input logic portB, input pixelAddrT pa);
		logic expHit;
		string suffix;
		expHit = modelHit(pa);
		suffix = portB ? "B" : "A";
		checkValue(testName, {"hit", suffix}, expHit, portB ? hitB : hitA);
		checkValue(testName, {"miss", suffix}, !expHit, portB ? missB : missA);
		if (expHit) begin
			checkValue(testName, {"data", suffix}, modelPixel(pa), portB ? lookDataB : lookDataA);
		end
	endtask

	task automatic lookupOne(input string testName, input logic portB, input pixelAddrT pa);
		requestLookup(portB, pa);
		awaitResponse(testName, !portB, portB);
		checkPort(testName, portB, pa);
	endtask

	task automatic lookupPair(input string testName, input pixelAddrT pa, input pixelAddrT pb);
		requestLookup(1'b0, pa);
		requestLookup(1'b1, pb);
		awaitResponse(testName, 1'b1, 1'b1);
		checkPort(testName, 1'b0, pa);
		checkPort(testName, 1'b1, pb);
	endtask

	// random words, each on a line that is still free
	task automatic fillRandom(input int count);
		wordAddrT addr;
		filledWords.delete();
		for (int i = 0; i < count; i++) begin
			do begin
				addr = wordAddrT'(randBits(17));
			end while (modelActive[modelIndex(addr)]);
			writeWord(addr, randBits(64));
			filledWords.push_back(addr);
		end
	endtask

	`include "cacheTests.svh"

	initial begin
		lfsrState = lfsrSeed;
		rstN = 1'b0;
		clearCache = 1'b0;
		trueColor = 1'b1;
		wrValid = 1'b0;
		wrAddr = '0;
		wrData = '0;
		lookValidA = 1'b0;
		lookAddrA = '0;
		lookValidB = 1'b0;
		lookAddrB = '0;
		foreach (modelActive[i]) modelActive[i] = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
		// quiet outputs straight out of reset
		checkValue("reset", "hitA", 0, hitA);
		checkValue("reset", "missA", 0, missA);
		checkValue("reset", "hitB", 0, hitB);
		checkValue("reset", "missB", 0, missB);
		testEmptyAfterReset();
		testFillThenRead();
		testDualPorts();
		testFormatConflict();
		testStickyMiss();
		testClearAndWrite();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/textureCache.sv */
// texture cache top with line store, active bits, two lookup ports and their read interfaces
`timescale 1ns/10ps
`default_nettype none

module textureCache
	import texAddrPkg::*, texCacheCfgPkg::*;
#(
	parameter int lineIndexBits = defaultLineIndexBits
) (
	input  logic clk,
	input  logic rstN,
	input  logic clearCache,
	// texture format of both the write snoop and the lookups
	input  logic trueColor,

	// memory write snoop, one word per cycle
	input  logic wrValid,
	input  wordAddrT wrAddr,
	input  cacheWordT wrData,

	// lookup port A
	input  logic lookValidA,
	input  pixelAddrT lookAddrA,
	output pixelT lookDataA,
	output logic hitA,
	output logic missA,

	// lookup port B
	input  logic lookValidB,
	input  pixelAddrT lookAddrB,
	output pixelT lookDataB,
	output logic hitB,
	output logic missB
);

	// fill notification from the store to the active bits
	logic [lineIndexBits-1:0] fillIndex;
	logic fillStrobe;

	// one read path per lookup port
	cacheReadIf #(.lineIndexBits(lineIndexBits)) readIfA ();
	cacheReadIf #(.lineIndexBits(lineIndexBits)) readIfB ();

	// tags and data
	lineStore #(
		.lineIndexBits(lineIndexBits)
	) lineStore_i (
		.clk(clk),
		.wrValid(wrValid),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.trueColor(trueColor),
		.fillIndex(fillIndex),
		.fillStrobe(fillStrobe),
		.readA(readIfA.store),
		.readB(readIfB.store)
	);

	// valid state of every line
	lineValidBits #(
		.lineIndexBits(lineIndexBits)
	) lineValidBits_i (
		.clk(clk),
		.rstN(rstN),
		.clearCache(clearCache),
		.fillIndex(fillIndex),
		.fillStrobe(fillStrobe),
		.readA(readIfA.valid),
		.readB(readIfB.valid)
	);

	// first lookup pipeline
	lookupPort #(
		.lineIndexBits(lineIndexBits)
	) portA (
		.clk(clk),
		.rstN(rstN),
		.lookValid(lookValidA),
		.lookAddr(lookAddrA),
		.trueColor(trueColor),
		.lookData(lookDataA),
		.hit(hitA),
		.miss(missA),
		.rd(readIfA.port)
	);

	// second lookup pipeline, fully independent of A
	lookupPort #(
		.lineIndexBits(lineIndexBits)
	) portB (
		.clk(clk),
		.rstN(rstN),
		.lookValid(lookValidB),
		.lookAddr(lookAddrB),
		.trueColor(trueColor),
		.lookData(lookDataB),
		.hit(hitB),
		.miss(missB),
		.rd(readIfB.port)
	);

endmodule

`default_nettype wire
